/* verilog.f */
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_exec.sv
source/rv_core.sv
verification/tb_clock.sv
verification/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f verilog.f -o tb_rv_core

output=$(./obj_dir/tb_rv_core 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

/* verification/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    localparam int          CLK_NS       = 4;
    localparam int          RESET_CYCLES = 3;
    localparam int          NUM_RETIRE   = 200;
    localparam int          MAX_CYCLES   = 8;   // per retirement, worst ack delay
    localparam int          PROG_WORDS   = 64;
    localparam logic [15:0] LFSR_SEED    = 16'd766;

    logic              clk;
    logic              reset_n;
    logic              wb_ack;
    logic [XLEN-1:0]   wb_dat;
    logic [XLEN-1:0]   wb_adr;
    logic [XLEN-1:0]   wb_dat_out;
    logic              wb_we;
    logic [3:0]        wb_sel;
    logic              wb_stb;
    logic              wb_cyc;
    logic              rf_we;
    logic [REG_AW-1:0] rf_rd;
    logic [XLEN-1:0]   rf_data;

    logic [XLEN-1:0]   program_mem [0:PROG_WORDS-1];
    logic [XLEN-1:0]   shadow_regs [0:NUM_REGS-1];
    logic [15:0]       lfsr_state;
    rf_write_t         exp_writes [$];
    logic [PC_W-1:0]   model_pc;
    int                retired;
    int                since_ack;
    logic              seen_ack;
    logic              stb_prev;
    logic              run_done;
    int                mem_wait;
    logic              mem_busy;

    tb_clock clock_gen
    (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    rv_core rv_core_inst
    (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .o_wb_adr  (wb_adr),
        .o_wb_dat  (wb_dat_out),
        .i_wb_dat  (wb_dat),
        .o_wb_we   (wb_we),
        .o_wb_sel  (wb_sel),
        .o_wb_stb  (wb_stb),
        .i_wb_ack  (wb_ack),
        .o_wb_cyc  (wb_cyc),
        .o_rf_we   (rf_we),
        .o_rf_rd   (rf_rd),
        .o_rf_data (rf_data)
    );

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_write(input rf_write_t got, input rf_write_t exp);
        if (got !== exp)
            stop_on_failure($sformatf(
                "CHECK FAILED at %0t: write we=%b x%0d=%h, expected we=%b x%0d=%h",
                $time, got.we, got.rd, got.data, exp.we, exp.rd, exp.data));
    endtask

    task automatic compare_pc(input logic [PC_W-1:0] got, input logic [PC_W-1:0] exp,
                              input string what);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s %h, expected %h",
                $time, what, {got, 2'b00}, {exp, 2'b00}));
    endtask

    task automatic compare_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                input string what);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s %h, expected %h",
                $time, what, got, exp));
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                $time, what, got, exp));
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp)
            stop_on_failure($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                $time, what, got, exp));
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] step_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = step_lfsr(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ISA model on the shadow registers, returns the expected trace entry
    function automatic rf_write_t ref_exec(input logic [31:0] instr, input logic [PC_W-1:0] pc,
                                           output logic [PC_W-1:0] next_pc);
        rf_write_t       res;
        logic [6:0]      f7;
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] tgt;
        logic            wr;
        logic            taken;
        f7      = instr[31:25];
        f3      = instr[14:12];
        a       = shadow_regs[instr[19:15]];
        b       = shadow_regs[instr[24:20]];
        wr      = 1'b0;
        res     = '0;
        next_pc = pc + 30'd1;
        case (instr[6:0])
            7'b0110011:
            begin
                if (f7 == 7'b0000000 || (f7 == 7'b0100000 && f3 == 3'b000))
                begin
                    wr = 1'b1;
                    case (f3)
                        3'b000:  res.data = (f7 == 7'b0100000) ? a - b : a + b;
                        3'b001:  res.data = a << b[4:0];
                        3'b010:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  res.data = a ^ b;
                        3'b101:  res.data = a >> b[4:0];
                        3'b110:  res.data = a | b;
                        3'b111:  res.data = a & b;
                        default: wr = 1'b0;
                    endcase
                end
            end
            7'b0010011:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
                wr  = 1'b1;
                case (f3)
                    3'b000:  res.data = a + imm;
                    3'b100:  res.data = a ^ imm;
                    3'b110:  res.data = a | imm;
                    3'b111:  res.data = a & imm;
                    default: wr = 1'b0;    // shifts by immediate unsupported
                endcase
            end
            7'b0110111:
            begin
                wr       = 1'b1;
                res.data = {instr[31:12], 12'b0};
            end
            7'b1100011:
            begin
                imm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                taken = (f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b);
                tgt   = {pc, 2'b00} + imm;
                if (taken)
                    next_pc = tgt[31:2];
            end
            7'b1101111:
            begin
                imm      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
                tgt      = {pc, 2'b00} + imm;
                next_pc  = tgt[31:2];
                wr       = 1'b1;
                res.data = {pc + 30'd1, 2'b00};
            end
            default: ;
        endcase
        res.rd = instr[11:7];
        res.we = wr && (instr[11:7] != 5'd0);
        return res;
    endfunction

    task automatic build_program();
        int          kind;
        int          target;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] off;
        for (int i = 0; i < PROG_WORDS - 1; i++)
        begin
            kind = int'(take_bits(4));
            rd   = 5'(take_bits(3));
            rs1  = 5'(take_bits(3));
            rs2  = 5'(take_bits(3));
            case (kind)
                0:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
                1:  program_mem[i] = enc_r(7'b0100000, rs2, rs1, 3'b000, rd);  // sub
                2:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
                3:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
                4:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
                5:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b010, rd);
                6:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b001, rd);
                7:  program_mem[i] = enc_r(7'b0000000, rs2, rs1, 3'b101, rd);
                8:  program_mem[i] = enc_i(12'(take_bits(12)), rs1, 3'b000, rd);
                9:  program_mem[i] = enc_i(12'(take_bits(12)), rs1, 3'b111, rd);
                10: program_mem[i] = enc_i(12'(take_bits(12)), rs1, 3'b110, rd);
                11: program_mem[i] = enc_i(12'(take_bits(12)), rs1, 3'b100, rd);
                12: program_mem[i] = {20'(take_bits(20)), rd, 7'b0110111};
                13:
                begin
                    f3     = take_bits(1) ? 3'b001 : 3'b000;   // bne or beq
                    target = i + int'($signed(4'(take_bits(4))));
                    if (target < 0)
                        target = 0;
                    if (target > PROG_WORDS - 1)
                        target = PROG_WORDS - 1;
                    if (target == i)
                        target = i + 1;
                    off = 32'((target - i) * 4);
                    program_mem[i] = enc_b(off[12:0], rs2, rs1, f3);
                end
                14:
                begin
                    target = i + 1 + int'(take_bits(3));    // forward only
                    if (target > PROG_WORDS - 1)
                        target = PROG_WORDS - 1;
                    off = 32'((target - i) * 4);
                    program_mem[i] = enc_j(off[20:0], rd);
                end
                default: program_mem[i] = {25'(take_bits(25)), 7'b0000011};  // load opcode
            endcase
        end
        program_mem[PROG_WORDS-1] = enc_j(21'd0, 5'd0);   // parks the core
    endtask

    // slave answers after 0 to 3 wait cycles
    always @(negedge clk)
    begin
        if (!reset_n || wb_ack)
        begin
            wb_ack <= 1'b0;
            wb_dat <= '0;
        end
        else if (wb_stb)
        begin
            if (!mem_busy)
            begin
                mem_wait = int'(take_bits(2));
                mem_busy = 1'b1;
            end
            if (mem_wait == 0)
            begin
                wb_ack   <= 1'b1;
                wb_dat   <= program_mem[wb_adr[7:2]];
                mem_busy = 1'b0;
            end
            else
                mem_wait = mem_wait - 1;
        end
    end

    always @(posedge clk)
    begin
        rf_write_t       got;
        rf_write_t       exp;
        logic [PC_W-1:0] next_pc;
        if (reset_n && !run_done)
        begin
            since_ack++;
            if (rf_we)
            begin
                got.we   = rf_we;
                got.rd   = rf_rd;
                got.data = rf_data;
                if (exp_writes.size() == 0)
                    stop_on_failure($sformatf(
                        "register write to x%0d that no instruction makes, at %0t",
                        rf_rd, $time));
                compare_write(got, exp_writes.pop_front());
            end
            if (wb_stb && !stb_prev && seen_ack)
                compare_count(since_ack, 3, "cycles from ack to next strobe");
            if (wb_stb && wb_ack)
            begin
                compare_pc(wb_adr[XLEN-1:2], model_pc, "fetch address");
                compare_flag(wb_cyc, 1'b1, "cyc in ack cycle");
                compare_flag(wb_we, 1'b0, "write enable in fetch");
                compare_flag(&wb_sel, 1'b1, "byte selects");
                compare_word(wb_dat_out, '0, "write data in fetch");
                if (exp_writes.size() != 0)
                    stop_on_failure($sformatf(
                        "expected register write never came, at %0t", $time));
                if (seen_ack)
                    retired++;
                seen_ack  = 1'b1;
                since_ack = 0;
                if (retired == NUM_RETIRE)
                    run_done = 1'b1;
                else
                begin
                    exp = ref_exec(program_mem[model_pc[5:0]], model_pc, next_pc);
                    if (exp.we)
                    begin
                        exp_writes.push_back(exp);
                        shadow_regs[exp.rd] = exp.data;
                    end
                    model_pc = next_pc;
                end
            end
            stb_prev = wb_stb;
        end
    end

    initial
    begin
        wb_ack     <= 1'b0;
        wb_dat     <= '0;
        lfsr_state = LFSR_SEED;
        model_pc   = RESET_PC;
        retired    = 0;
        since_ack  = 0;
        seen_ack   = 1'b0;
        stb_prev   = 1'b0;
        run_done   = 1'b0;
        mem_wait   = 0;
        mem_busy   = 1'b0;
        for (int r = 0; r < NUM_REGS; r++)
            shadow_regs[r] = '0;
        build_program();

        @(posedge reset_n);
        compare_flag(wb_cyc, 1'b0, "cyc after reset");
        compare_flag(wb_stb, 1'b0, "stb after reset");
        compare_flag(wb_we, 1'b0, "we after reset");
        compare_flag(rf_we, 1'b0, "rf_we after reset");

        wait (run_done);
        if (exp_writes.size() == 0)
        begin
            $display("sim passed");
            $finish;
        end
        else
        begin
            $display("register writes still outstanding at end of run");
            $display("sim failed");
            $fatal(1, "run aborted");
        end
    end

    initial
    begin
        #((RESET_CYCLES + 2 + NUM_RETIRE * MAX_CYCLES) * CLK_NS);
        stop_on_failure($sformatf("timeout: core stopped retiring after %0d instructions",
            retired));
    end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
    output logic o_clk,
    output logic o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;  // 4 ns period
    end

    initial
    begin
        o_reset_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset_n,
    output logic [XLEN-1:0]   o_wb_adr,
    output logic [XLEN-1:0]   o_wb_dat,
    input  logic [XLEN-1:0]   i_wb_dat,
    output logic              o_wb_we,
    output logic [3:0]        o_wb_sel,
    output logic              o_wb_stb,
    input  logic              i_wb_ack,
    output logic              o_wb_cyc,
    output logic              o_rf_we,      // retirement trace
    output logic [REG_AW-1:0] o_rf_rd,
    output logic [XLEN-1:0]   o_rf_data
);

    logic            w_fetch_valid;
    logic [XLEN-1:0] w_instr;
    logic [PC_W-1:0] w_fetch_pc;
    logic            w_dec_valid;
    dec_ctrl_t       w_dec;
    logic [XLEN-1:0] w_rs1_val;
    logic [XLEN-1:0] w_rs2_val;
    rf_write_t       w_write;
    logic            w_retire;
    redirect_t       w_redirect;

    rv_fetch u_fetch
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat),
        .i_retire       (w_retire),
        .i_redirect     (w_redirect),
        .o_wb_adr       (o_wb_adr),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_fetch_valid  (w_fetch_valid),
        .o_instr        (w_instr),
        .o_pc           (w_fetch_pc)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_valid  (w_fetch_valid),
        .i_instr        (w_instr),
        .i_pc           (w_fetch_pc),
        .o_dec_valid    (w_dec_valid),
        .o_dec          (w_dec)
    );

    rv_regfile u_regfile
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_rs1          (w_dec.rs1),
        .i_rs2          (w_dec.rs2),
        .i_write        (w_write),
        .o_rs1_val      (w_rs1_val),
        .o_rs2_val      (w_rs2_val)
    );

    rv_exec u_exec
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_dec_valid    (w_dec_valid),
        .i_dec          (w_dec),
        .i_rs1_val      (w_rs1_val),
        .i_rs2_val      (w_rs2_val),
        .o_write        (w_write),
        .o_retire       (w_retire),
        .o_redirect     (w_redirect)
    );

    // read-only bus, no store path
    assign o_wb_dat  = '0;
    assign o_wb_we   = 1'b0;
    assign o_wb_sel  = '1;

    assign o_rf_we   = w_write.we;
    assign o_rf_rd   = w_write.rd;
    assign o_rf_data = w_write.data;

endmodule

`default_nettype wire

/* source/rv_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_exec
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_dec_valid,
    input  dec_ctrl_t       i_dec,
    input  logic [XLEN-1:0] i_rs1_val,
    input  logic [XLEN-1:0] i_rs2_val,
    output rf_write_t       o_write,
    output logic            o_retire,
    output redirect_t       o_redirect
);

    logic [XLEN-1:0]   w_op_b;
    logic [XLEN-1:0]   w_alu;
    logic [XLEN-1:0]   w_result;
    logic              w_eq;
    logic              w_take;
    logic [PC_W-1:0]   w_target;

    logic              r_we;
    logic              r_retire;
    logic              r_take;
    logic [REG_AW-1:0] r_rd;
    logic [XLEN-1:0]   r_data;
    logic [PC_W-1:0]   r_target;

    assign w_op_b = i_dec.use_imm ? i_dec.imm : i_rs2_val;

    always_comb
    begin
        case (i_dec.alu_op)
            ALU_ADD:    w_alu = i_rs1_val + w_op_b;
            ALU_SUB:    w_alu = i_rs1_val - w_op_b;
            ALU_AND:    w_alu = i_rs1_val & w_op_b;
            ALU_OR:     w_alu = i_rs1_val | w_op_b;
            ALU_XOR:    w_alu = i_rs1_val ^ w_op_b;
            ALU_SLT:    w_alu = {{(XLEN-1){1'b0}}, $signed(i_rs1_val) < $signed(w_op_b)};
            ALU_SLL:    w_alu = i_rs1_val << w_op_b[4:0];
            ALU_SRL:    w_alu = i_rs1_val >> w_op_b[4:0];
            ALU_PASS_B: w_alu = w_op_b;
            default:    w_alu = '0;
        endcase
    end

    assign w_eq     = (i_rs1_val == i_rs2_val);
    assign w_take   = i_dec.is_jump || (i_dec.is_branch && (w_eq ^ i_dec.branch_ne));
    assign w_target = i_dec.pc + i_dec.imm[XLEN-1:2];   // byte offset to words
    assign w_result = i_dec.is_jump ? {i_dec.pc_p4, 2'b00} : w_alu;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_we     <= 1'b0;
            r_retire <= 1'b0;
            r_take   <= 1'b0;
        end
        else
        begin
            r_we     <= i_dec_valid && i_dec.reg_write && (i_dec.rd != '0);
            r_retire <= i_dec_valid;
            r_take   <= i_dec_valid && w_take;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_dec_valid)
        begin
            r_rd     <= i_dec.rd;
            r_data   <= w_result;
            r_target <= w_target;
        end
    end

    assign o_write.we        = r_we;
    assign o_write.rd        = r_rd;
    assign o_write.data      = r_data;
    assign o_retire          = r_retire;
    assign o_redirect.take   = r_take;
    assign o_redirect.target = r_target;

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic [REG_AW-1:0] i_rs1,
    input  logic [REG_AW-1:0] i_rs2,
    input  rf_write_t         i_write,
    output logic [XLEN-1:0]   o_rs1_val,
    output logic [XLEN-1:0]   o_rs2_val
);

    logic [XLEN-1:0] r_regs [1:NUM_REGS-1];    // x0 has no storage

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                r_regs[i] <= '0;
        end
        else if (i_write.we && (i_write.rd != '0))
        begin
            r_regs[i_write.rd] <= i_write.data;
        end
    end

    assign o_rs1_val = (i_rs1 == '0) ? '0 : r_regs[i_rs1];
    assign o_rs2_val = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

    // execute filters x0 before raising we
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_write.we |-> (i_write.rd != '0));

endmodule

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_fetch_valid,
    input  logic [XLEN-1:0] i_instr,
    input  logic [PC_W-1:0] i_pc,
    output logic            o_dec_valid,
    output dec_ctrl_t       o_dec
);

    logic [XLEN-1:0] r_instr;
    logic [PC_W-1:0] r_pc;
    logic            r_dec_valid;

    logic [6:0]      w_opcode;
    logic [2:0]      w_funct3;
    logic [6:0]      w_funct7;
    logic [XLEN-1:0] w_imm_i;
    logic [XLEN-1:0] w_imm_b;
    logic [XLEN-1:0] w_imm_u;
    logic [XLEN-1:0] w_imm_j;
    dec_ctrl_t       w_ctrl;

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_valid)
        begin
            r_instr <= i_instr;
            r_pc    <= i_pc;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_dec_valid <= 1'b0;
        else
            r_dec_valid <= i_fetch_valid;
    end

    assign w_opcode = r_instr[6:0];
    assign w_funct3 = r_instr[14:12];
    assign w_funct7 = r_instr[31:25];

    assign w_imm_i = {{20{r_instr[31]}}, r_instr[31:20]};
    assign w_imm_b = {{19{r_instr[31]}}, r_instr[31], r_instr[7],
                      r_instr[30:25], r_instr[11:8], 1'b0};
    assign w_imm_u = {r_instr[31:12], 12'b0};
    assign w_imm_j = {{11{r_instr[31]}}, r_instr[31], r_instr[19:12],
                      r_instr[20], r_instr[30:21], 1'b0};

    always_comb
    begin
        w_ctrl        = '0;
        w_ctrl.pc     = r_pc;
        w_ctrl.pc_p4  = r_pc + 1'b1;
        w_ctrl.rd     = r_instr[11:7];
        w_ctrl.rs1    = r_instr[19:15];
        w_ctrl.rs2    = r_instr[24:20];
        w_ctrl.alu_op = ALU_ADD;

        case (w_opcode)
            OPC_OP:
            begin
                w_ctrl.reg_write = 1'b1;
                case (w_funct3)
                    F3_ADD_SUB: w_ctrl.alu_op = (w_funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     w_ctrl.alu_op = ALU_SLL;
                    F3_SLT:     w_ctrl.alu_op = ALU_SLT;
                    F3_XOR:     w_ctrl.alu_op = ALU_XOR;
                    F3_SRL:     w_ctrl.alu_op = ALU_SRL;
                    F3_OR:      w_ctrl.alu_op = ALU_OR;
                    F3_AND:     w_ctrl.alu_op = ALU_AND;
                    default:    w_ctrl.reg_write = 1'b0;   // sltu
                endcase
                // only sub takes the alternate funct7
                if (w_funct7 != F7_BASE && !(w_funct7 == F7_ALT && w_funct3 == F3_ADD_SUB))
                    w_ctrl.reg_write = 1'b0;
            end
            OPC_OP_IMM:
            begin
                w_ctrl.imm       = w_imm_i;
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.reg_write = 1'b1;
                case (w_funct3)
                    F3_ADD_SUB: w_ctrl.alu_op = ALU_ADD;
                    F3_XOR:     w_ctrl.alu_op = ALU_XOR;
                    F3_OR:      w_ctrl.alu_op = ALU_OR;
                    F3_AND:     w_ctrl.alu_op = ALU_AND;
                    default:    w_ctrl.reg_write = 1'b0;
                endcase
            end
            OPC_LUI:
            begin
                w_ctrl.imm       = w_imm_u;
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.reg_write = 1'b1;
                w_ctrl.alu_op    = ALU_PASS_B;
            end
            OPC_BRANCH:
            begin
                w_ctrl.imm       = w_imm_b;
                w_ctrl.is_branch = (w_funct3 == F3_BEQ) || (w_funct3 == F3_BNE);
                w_ctrl.branch_ne = (w_funct3 == F3_BNE);
            end
            OPC_JAL:
            begin
                w_ctrl.imm       = w_imm_j;
                w_ctrl.is_jump   = 1'b1;
                w_ctrl.reg_write = 1'b1;    // link
            end
            default: ;  // retires as a nop
        endcase
    end

    assign o_dec_valid = r_dec_valid;
    assign o_dec       = w_ctrl;

endmodule

`default_nettype wire

/* source/rv_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_wb_ack,
    input  logic [XLEN-1:0] i_wb_dat,
    input  logic            i_retire,
    input  redirect_t       i_redirect,
    output logic [XLEN-1:0] o_wb_adr,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output logic            o_fetch_valid,
    output logic [XLEN-1:0] o_instr,
    output logic [PC_W-1:0] o_pc
);

    fetch_state_e    r_state;
    logic            r_start;   // first fetch after reset release
    logic [PC_W-1:0] r_pc;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_state <= IDLE;
            r_start <= 1'b1;
        end
        else
        begin
            case (r_state)
                IDLE:
                begin
                    if (r_start || i_retire)
                    begin
                        r_state <= BUS;
                        r_start <= 1'b0;
                    end
                end
                BUS:
                begin
                    if (i_wb_ack)
                        r_state <= IDLE;
                end
                default: r_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_pc <= RESET_PC;
        else if (i_retire)
            r_pc <= i_redirect.take ? i_redirect.target : r_pc + 1'b1;
    end

    assign o_wb_cyc      = (r_state == BUS);
    assign o_wb_stb      = (r_state == BUS);
    assign o_wb_adr      = {r_pc, 2'b00};
    assign o_fetch_valid = o_wb_stb && i_wb_ack;
    assign o_instr       = i_wb_dat;    // valid in the ack cycle only
    assign o_pc          = r_pc;

    // one instruction in flight, no retire during a bus read
    a_no_retire_in_cyc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_wb_cyc |-> !i_retire);

    // strobe holds until the slave answers
    a_stb_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (o_wb_stb && !i_wb_ack) |=> o_wb_stb);

endmodule

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN     = 32;
    localparam int PC_W     = 30;   // word address, pc[31:2]
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    localparam logic [PC_W-1:0] RESET_PC = '0;

    // funct3 / funct7 codes used by decode
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // sub

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic {
        IDLE,
        BUS
    } fetch_state_e;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [PC_W-1:0]   pc_p4;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
        alu_op_e           alu_op;
        logic              use_imm;
        logic              reg_write;
        logic              is_branch;
        logic              branch_ne;
        logic              is_jump;
    } dec_ctrl_t;

    typedef struct packed {
        logic            take;
        logic [PC_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } rf_write_t;

endpackage

`default_nettype wire
